//--- mips_ex_cfg.svh
`ifndef MIPS_EX_CFG_SVH
`define MIPS_EX_CFG_SVH

// Datapath width of the execute stage
`define EX_DATA_W 32

// Shift amount field, enough to cover every bit of a word
`define EX_SHAMT_W 5

// One shift-add or restoring-subtract step per bit of the word
`define EX_MD_ITER `EX_DATA_W

`endif

//--- mips_ex_pkg.sv
`include "mips_ex_cfg.svh"

package mips_ex_pkg;

	typedef logic [`EX_DATA_W-1:0] word_t; // Register sized operand or result
	typedef logic [`EX_SHAMT_W-1:0] shamt_t; // Shift amount field
	typedef logic [5:0] opcode_t; // Bits 31..26 of the instruction
	typedef logic [5:0] funct_t; // Bits 5..0 of an R-type instruction
	typedef logic [15:0] imm_t; // Bits 15..0 of an I-type instruction

	// Four-bit ALU control codes as used by the datapath
	typedef enum logic [3:0]
	{
		ADD = 4'b0000, // ADD, ADDU, ADDI
		SUB = 4'b0100, // SUB, BEQ, BNE
		AND = 4'b1000, // AND, ANDI
		OR = 4'b1010, // OR, ORI
		NOR = 4'b1100, // Inverted OR
		SLT = 4'b0101, // Signed compare for SLT and SLTI
		SLL = 4'b0010, // Logical left shift
		SRL = 4'b0011, // Logical right shift
		MUL = 4'b1001, // Low word of the product
		MFHI = 4'b1110, // Read Hi
		MFLO = 4'b0111, // Read Lo
		NOP = 4'b1111 // Zero result
	} alu_op_t;

	// Multiply/divide sequencer
	typedef enum logic [1:0]
	{
		IDLE = 2'd0, // Waiting for a start strobe
		MULT = 2'd1, // Shift-add steps
		DIV = 2'd2, // Restoring subtract steps
		DONE = 2'd3 // Sign fix and Hi/Lo write
	} md_state_t;

endpackage

//--- alu_decoder.sv
`timescale 1ns/1ps
`include "mips_ex_cfg.svh"

module alu_decoder (
	input  logic                 in_valid,
	input  mips_ex_pkg::opcode_t opcode,
	input  mips_ex_pkg::funct_t  funct,
	input  mips_ex_pkg::imm_t    imm,
	input  mips_ex_pkg::word_t   rt_value,
	input  logic                 md_ready,
	output logic                 alu_issue,
	output mips_ex_pkg::alu_op_t alu_op,
	output mips_ex_pkg::word_t   operand_b,
	output logic                 is_branch,
	output logic                 branch_ne,
	output logic                 decode_illegal,
	output logic                 md_start_mult,
	output logic                 md_start_div
);
	localparam int IMM_W = $bits(mips_ex_pkg::imm_t);

	localparam mips_ex_pkg::opcode_t OPC_SPECIAL = 6'h00; // R-type
	localparam mips_ex_pkg::opcode_t OPC_SPECIAL2 = 6'h1c; // Holds MUL
	localparam mips_ex_pkg::opcode_t OPC_BEQ = 6'h04;
	localparam mips_ex_pkg::opcode_t OPC_BNE = 6'h05;
	localparam mips_ex_pkg::opcode_t OPC_ADDI = 6'h08;
	localparam mips_ex_pkg::opcode_t OPC_SLTI = 6'h0a;
	localparam mips_ex_pkg::opcode_t OPC_ANDI = 6'h0c;
	localparam mips_ex_pkg::opcode_t OPC_ORI = 6'h0d;

	localparam mips_ex_pkg::funct_t FN_SLL = 6'h00;
	localparam mips_ex_pkg::funct_t FN_SRL = 6'h02;
	localparam mips_ex_pkg::funct_t FN_MFHI = 6'h10;
	localparam mips_ex_pkg::funct_t FN_MFLO = 6'h12;
	localparam mips_ex_pkg::funct_t FN_MULT = 6'h18;
	localparam mips_ex_pkg::funct_t FN_DIV = 6'h1a;
	localparam mips_ex_pkg::funct_t FN_ADD = 6'h20;
	localparam mips_ex_pkg::funct_t FN_ADDU = 6'h21;
	localparam mips_ex_pkg::funct_t FN_SUB = 6'h22;
	localparam mips_ex_pkg::funct_t FN_AND = 6'h24;
	localparam mips_ex_pkg::funct_t FN_OR = 6'h25;
	localparam mips_ex_pkg::funct_t FN_NOR = 6'h27;
	localparam mips_ex_pkg::funct_t FN_SLT = 6'h2a;
	localparam mips_ex_pkg::funct_t FN_MUL = 6'h02; // Under SPECIAL2

	logic accept; // Handshake completes this cycle
	logic is_mult; // Goes to the sequencer instead of the ALU
	logic is_div;
	logic sext_imm; // ADDI, SLTI, branches
	logic zext_imm; // ANDI, ORI
	mips_ex_pkg::word_t imm_sext;
	mips_ex_pkg::word_t imm_zext;

	assign accept = in_valid && md_ready; // Nothing enters while a MULT/DIV runs
	assign imm_sext = {{(`EX_DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
	assign imm_zext = {{(`EX_DATA_W-IMM_W){1'b0}}, imm};

	always_comb
	begin
		alu_op = mips_ex_pkg::NOP; // Unknown encodings fall through to NOP
		is_mult = 1'b0;
		is_div = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		sext_imm = 1'b0;
		zext_imm = 1'b0;
		decode_illegal = 1'b0;
		case (opcode)
			OPC_SPECIAL:
			begin
				case (funct)
					FN_ADD, FN_ADDU: alu_op = mips_ex_pkg::ADD; // No overflow trap
					FN_SUB: alu_op = mips_ex_pkg::SUB;
					FN_AND: alu_op = mips_ex_pkg::AND;
					FN_OR: alu_op = mips_ex_pkg::OR;
					FN_NOR: alu_op = mips_ex_pkg::NOR;
					FN_SLT: alu_op = mips_ex_pkg::SLT;
					FN_SLL: alu_op = mips_ex_pkg::SLL;
					FN_SRL: alu_op = mips_ex_pkg::SRL;
					FN_MFHI: alu_op = mips_ex_pkg::MFHI;
					FN_MFLO: alu_op = mips_ex_pkg::MFLO;
					FN_MULT: is_mult = 1'b1; // ALU op stays NOP
					FN_DIV: is_div = 1'b1;
					default: decode_illegal = 1'b1;
				endcase
			end
			OPC_SPECIAL2:
			begin
				if (funct == FN_MUL)
					alu_op = mips_ex_pkg::MUL;
				else
					decode_illegal = 1'b1;
			end
			OPC_ADDI:
			begin
				alu_op = mips_ex_pkg::ADD;
				sext_imm = 1'b1;
			end
			OPC_SLTI:
			begin
				alu_op = mips_ex_pkg::SLT;
				sext_imm = 1'b1;
			end
			OPC_ANDI:
			begin
				alu_op = mips_ex_pkg::AND;
				zext_imm = 1'b1;
			end
			OPC_ORI:
			begin
				alu_op = mips_ex_pkg::OR;
				zext_imm = 1'b1;
			end
			OPC_BEQ, OPC_BNE:
			begin
				alu_op = mips_ex_pkg::SUB; // Difference feeds the zero test
				is_branch = 1'b1;
				branch_ne = (opcode == OPC_BNE);
				sext_imm = 1'b1; // Offset field extended like ADDI
			end
			default: decode_illegal = 1'b1;
		endcase
	end

	// Second operand source
	assign operand_b = sext_imm ? imm_sext : (zext_imm ? imm_zext : rt_value);

	assign alu_issue = accept && !is_mult && !is_div; // Illegal ones issue as NOP
	assign md_start_mult = accept && is_mult;
	assign md_start_div = accept && is_div;

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "mips_ex_cfg.svh"

module alu (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 alu_issue,
	input  mips_ex_pkg::alu_op_t alu_op,
	input  mips_ex_pkg::word_t   operand_a,
	input  mips_ex_pkg::word_t   operand_b,
	input  mips_ex_pkg::shamt_t  shamt,
	input  logic                 is_branch,
	input  logic                 branch_ne,
	input  logic                 decode_illegal,
	input  mips_ex_pkg::word_t   hi,
	input  mips_ex_pkg::word_t   lo,
	output logic                 out_valid,
	output mips_ex_pkg::word_t   result,
	output logic                 branch,
	output logic                 branch_taken,
	output logic                 illegal
);
	mips_ex_pkg::word_t alu_sum;
	mips_ex_pkg::word_t alu_diff; // Also the branch compare
	mips_ex_pkg::word_t alu_prod; // Low word only
	mips_ex_pkg::word_t alu_value; // Next result
	logic less_than;
	logic cond_met; // Branch condition before issue gating

	assign alu_sum = operand_a + operand_b;
	assign alu_diff = operand_a - operand_b;
	assign alu_prod = operand_a * operand_b; // Low word equal for signed and unsigned
	assign less_than = $signed(operand_a) < $signed(operand_b);
	assign cond_met = (alu_diff == '0) ^ branch_ne; // BEQ on zero, BNE on nonzero

	always_comb
	begin
		case (alu_op)
			mips_ex_pkg::ADD: alu_value = alu_sum;
			mips_ex_pkg::SUB: alu_value = alu_diff;
			mips_ex_pkg::AND: alu_value = operand_a & operand_b;
			mips_ex_pkg::OR: alu_value = operand_a | operand_b;
			mips_ex_pkg::NOR: alu_value = ~(operand_a | operand_b);
			mips_ex_pkg::SLT: alu_value = {{(`EX_DATA_W-1){1'b0}}, less_than};
			mips_ex_pkg::SLL: alu_value = operand_b << shamt; // rt is the shifted value
			mips_ex_pkg::SRL: alu_value = operand_b >> shamt; // Zero fill
			mips_ex_pkg::MUL: alu_value = alu_prod;
			mips_ex_pkg::MFHI: alu_value = hi;
			mips_ex_pkg::MFLO: alu_value = lo;
			default: alu_value = '0; // NOP and illegal
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			branch <= 1'b0;
			branch_taken <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			out_valid <= alu_issue; // One result per issue a cycle later
			branch <= alu_issue && is_branch;
			branch_taken <= alu_issue && is_branch && cond_met;
			illegal <= alu_issue && decode_illegal;
		end
	end

	// Result holds between issues
	always_ff @(posedge clk)
	begin
		if (alu_issue)
			result <= alu_value;
	end

	a_illegal_is_nop: assert property (
		@(posedge clk) disable iff (reset)
		(alu_issue && decode_illegal) |-> (alu_op == mips_ex_pkg::NOP)
	) else $error("Illegal instruction issued with an ALU operation other than NOP");

endmodule

//--- muldiv_unit.sv
`timescale 1ns/1ps
`include "mips_ex_cfg.svh"

module muldiv_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               md_start_mult,
	input  logic               md_start_div,
	input  mips_ex_pkg::word_t rs_value,
	input  mips_ex_pkg::word_t rt_value,
	output logic               md_ready,
	output mips_ex_pkg::word_t hi,
	output mips_ex_pkg::word_t lo
);
	localparam int W = `EX_DATA_W;
	localparam int CNT_W = $clog2(`EX_MD_ITER);

	mips_ex_pkg::md_state_t state;
	logic [CNT_W-1:0] step_cnt; // Steps left minus one
	logic [2*W-1:0] acc; // Mult {partial, multiplier}, div {remainder, quotient}
	mips_ex_pkg::word_t mag_b; // Multiplicand or divisor magnitude
	logic sign_a; // rs was negative
	logic sign_b; // rt was negative
	logic div_by_zero;
	logic op_div; // Selects the DONE write-back
	mips_ex_pkg::word_t mag_rs;
	mips_ex_pkg::word_t mag_rt;
	logic [W:0] add_step; // Upper half plus multiplicand, with carry
	logic [W:0] rem_shift; // Remainder with next dividend bit in
	logic [W:0] rem_trial; // Sign bit says restore
	logic [2*W-1:0] prod_signed;
	mips_ex_pkg::word_t quo_signed;
	mips_ex_pkg::word_t rem_signed;

	assign md_ready = (state == mips_ex_pkg::IDLE);

	assign mag_rs = rs_value[W-1] ? -rs_value : rs_value; // Most negative maps to itself
	assign mag_rt = rt_value[W-1] ? -rt_value : rt_value;

	// One shift-add step
	assign add_step = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, mag_b} : {(W+1){1'b0}});

	// One restoring-subtract step
	assign rem_shift = {acc[2*W-1:W], acc[W-1]};
	assign rem_trial = rem_shift - {1'b0, mag_b};

	// Sign correction applied in DONE
	assign prod_signed = (sign_a ^ sign_b) ? -acc : acc;
	assign quo_signed = div_by_zero ? '1 : ((sign_a ^ sign_b) ? -acc[W-1:0] : acc[W-1:0]);
	assign rem_signed = sign_a ? -acc[2*W-1:W] : acc[2*W-1:W]; // Follows the dividend

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= mips_ex_pkg::IDLE;
			step_cnt <= '0;
			hi <= '0;
			lo <= '0;
		end
		else
		begin
			case (state)
				mips_ex_pkg::IDLE:
				begin
					if (md_start_mult)
					begin
						state <= mips_ex_pkg::MULT;
						step_cnt <= CNT_W'(`EX_MD_ITER - 1);
					end
					else if (md_start_div)
					begin
						state <= mips_ex_pkg::DIV;
						step_cnt <= CNT_W'(`EX_MD_ITER - 1);
					end
				end
				mips_ex_pkg::MULT, mips_ex_pkg::DIV:
				begin
					if (step_cnt == '0)
						state <= mips_ex_pkg::DONE; // Last step happens on this edge
					else
						step_cnt <= step_cnt - 1'b1;
				end
				mips_ex_pkg::DONE:
				begin
					if (op_div)
					begin
						hi <= rem_signed;
						lo <= quo_signed;
					end
					else
					begin
						hi <= prod_signed[2*W-1:W];
						lo <= prod_signed[W-1:0];
					end
					state <= mips_ex_pkg::IDLE; // Ready again, Hi/Lo valid
				end
				default: state <= mips_ex_pkg::IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			mips_ex_pkg::IDLE:
			begin
				if (md_start_mult || md_start_div)
				begin
					acc <= {{W{1'b0}}, mag_rs}; // Multiplier or dividend in the low half
					mag_b <= mag_rt;
					sign_a <= rs_value[W-1];
					sign_b <= rt_value[W-1];
					div_by_zero <= (rt_value == '0);
					op_div <= md_start_div;
				end
			end
			mips_ex_pkg::MULT: acc <= {add_step, acc[W-1:1]}; // Shift product right
			mips_ex_pkg::DIV:
			begin
				if (!rem_trial[W])
					acc <= {rem_trial[W-1:0], acc[W-2:0], 1'b1}; // Subtract fits
				else
					acc <= {rem_shift[W-1:0], acc[W-2:0], 1'b0}; // Restore
			end
			default: ;
		endcase
	end

	a_start_when_idle: assert property (
		@(posedge clk) disable iff (reset)
		(md_start_mult || md_start_div) |-> (state == mips_ex_pkg::IDLE)
	) else $error("Multiply/divide start while the sequencer is busy");

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps
`include "mips_ex_cfg.svh"

module ex_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  mips_ex_pkg::opcode_t opcode,
	input  mips_ex_pkg::funct_t  funct,
	input  mips_ex_pkg::shamt_t  shamt,
	input  mips_ex_pkg::imm_t    imm,
	input  mips_ex_pkg::word_t   rs_value,
	input  mips_ex_pkg::word_t   rt_value,
	output logic                 in_ready,
	output logic                 out_valid,
	output mips_ex_pkg::word_t   result,
	output logic                 branch,
	output logic                 branch_taken,
	output logic                 illegal
);
	logic md_ready; // Low while MULT/DIV runs
	mips_ex_pkg::word_t hi;
	mips_ex_pkg::word_t lo;
	logic alu_issue;
	mips_ex_pkg::alu_op_t alu_op;
	mips_ex_pkg::word_t operand_b; // rt or extended immediate
	logic is_branch;
	logic branch_ne;
	logic decode_illegal;
	logic md_start_mult;
	logic md_start_div;

	assign in_ready = md_ready; // Stall only on the sequencer

	alu_decoder alu_decoder_inst (
		.in_valid       (in_valid),
		.opcode         (opcode),
		.funct          (funct),
		.imm            (imm),
		.rt_value       (rt_value),
		.md_ready       (md_ready),
		.alu_issue      (alu_issue),
		.alu_op         (alu_op),
		.operand_b      (operand_b),
		.is_branch      (is_branch),
		.branch_ne      (branch_ne),
		.decode_illegal (decode_illegal),
		.md_start_mult  (md_start_mult),
		.md_start_div   (md_start_div)
	);

	alu alu_inst (
		.clk            (clk),
		.reset          (reset),
		.alu_issue      (alu_issue),
		.alu_op         (alu_op),
		.operand_a      (rs_value),
		.operand_b      (operand_b),
		.shamt          (shamt),
		.is_branch      (is_branch),
		.branch_ne      (branch_ne),
		.decode_illegal (decode_illegal),
		.hi             (hi),
		.lo             (lo),
		.out_valid      (out_valid),
		.result         (result),
		.branch         (branch),
		.branch_taken   (branch_taken),
		.illegal        (illegal)
	);

	muldiv_unit muldiv_unit_inst (
		.clk           (clk),
		.reset         (reset),
		.md_start_mult (md_start_mult),
		.md_start_div  (md_start_div),
		.rs_value      (rs_value),
		.rt_value      (rt_value),
		.md_ready      (md_ready),
		.hi            (hi),
		.lo            (lo)
	);

endmodule

//--- tb_ex_tasks.svh
// Drives one instruction on the falling edge, once the stage can take it
task automatic issue(input mips_ex_pkg::opcode_t op, input mips_ex_pkg::funct_t fn,
		input mips_ex_pkg::shamt_t sh, input mips_ex_pkg::imm_t im,
		input mips_ex_pkg::word_t a, input mips_ex_pkg::word_t b,
		input logic want, input mips_ex_pkg::word_t exp, input logic [2:0] flags);
	int waited;
	@(negedge clk);
	wait_ready(waited);
	in_valid = 1'b1;
	opcode = op;
	funct = fn;
	shamt = sh;
	imm = im;
	rs_value = a;
	rt_value = b;
	if (want)
	begin
		exp_result_q.push_back(exp);
		exp_flags_q.push_back(flags); // {branch, branch_taken, illegal}
		due_q.push_back(cycles + 1); // Registered on the accepting edge
	end
endtask

// Holds in_valid low until in_ready, bounded by one multiply/divide
task automatic wait_ready(output int waited);
	waited = 0;
	while (!in_ready && waited < `EX_MD_ITER + 4)
	begin
		in_valid = 1'b0;
		@(negedge clk);
		waited++;
	end
	if (!in_ready)
	begin
		errors++;
		$display("in_ready stayed low for %0d cycles after a multiply or divide", waited);
	end
endtask

// Stops issuing and waits until every expected result has been seen
task automatic drain();
	@(negedge clk);
	in_valid = 1'b0;
	while (due_q.size() > 0)
		@(negedge clk);
endtask

// MULT or DIV, busy window, then Hi and Lo read back
task automatic run_muldiv(input mips_ex_pkg::funct_t fn, input mips_ex_pkg::word_t a,
		input mips_ex_pkg::word_t b, input mips_ex_pkg::word_t exp_hi,
		input mips_ex_pkg::word_t exp_lo);
	int waited;
	issue(OP_RTYPE, fn, '0, '0, a, b, 1'b0, '0, 3'b000);
	@(negedge clk);
	in_valid = 1'b0;
	check_flag("in_ready", in_ready, 1'b0); // Busy from the accepting edge
	wait_ready(waited);
	checks++;
	if (waited != `EX_MD_ITER + 1)
	begin
		errors++;
		$display("ERROR at %0t: in_ready latency got %0d, expected %0d",
			$time, waited, `EX_MD_ITER + 1);
	end
	issue(OP_RTYPE, FN_MFHI, '0, '0, '0, '0, 1'b1, exp_hi, 3'b000);
	issue(OP_RTYPE, FN_MFLO, '0, '0, '0, '0, 1'b1, exp_lo, 3'b000);
endtask

task automatic check_word(input string name, input mips_ex_pkg::word_t got,
		input mips_ex_pkg::word_t exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("ERROR at %0t: %s got %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("ERROR at %0t: %s got %b, expected %b", $time, name, got, exp);
	end
endtask

function automatic mips_ex_pkg::word_t ref_sext(input mips_ex_pkg::imm_t im);
	return mips_ex_pkg::word_t'($signed(im)); // Bit 15 copied upward
endfunction

function automatic mips_ex_pkg::word_t ref_zext(input mips_ex_pkg::imm_t im);
	return mips_ex_pkg::word_t'(im);
endfunction

function automatic mips_ex_pkg::word_t ref_slt(input mips_ex_pkg::word_t a,
		input mips_ex_pkg::word_t b);
	return ($signed(a) < $signed(b)) ? 1 : 0; // Signed compare
endfunction

// Full signed product, Hi in the upper word
function automatic logic [2*`EX_DATA_W-1:0] ref_mult(input mips_ex_pkg::word_t a,
		input mips_ex_pkg::word_t b);
	logic signed [2*`EX_DATA_W-1:0] wa;
	logic signed [2*`EX_DATA_W-1:0] wb;
	wa = $signed(a); // Sign extends
	wb = $signed(b);
	return wa * wb;
endfunction

// Truncating signed divide, remainder takes the dividend's sign
function automatic void ref_div(input mips_ex_pkg::word_t a, input mips_ex_pkg::word_t b,
		output mips_ex_pkg::word_t q, output mips_ex_pkg::word_t r);
	if (b == '0)
	begin
		q = '1; // Zero divisor
		r = a;
	end
	else
	begin
		q = $signed(a) / $signed(b);
		r = $signed(a) % $signed(b);
	end
endfunction

//--- tb_ex_stage.sv
`timescale 1ns/1ps
`include "mips_ex_cfg.svh"

module tb_ex_stage;
	localparam int N_INSTR = 117; // Issued over all tests
	localparam int TIMEOUT_CYCLES = N_INSTR * (`EX_MD_ITER + 4) + 200;

	localparam mips_ex_pkg::opcode_t OP_RTYPE = 6'h00;
	localparam mips_ex_pkg::opcode_t OP_SPECIAL2 = 6'h1c;
	localparam mips_ex_pkg::opcode_t OP_BEQ = 6'h04;
	localparam mips_ex_pkg::opcode_t OP_BNE = 6'h05;
	localparam mips_ex_pkg::opcode_t OP_ADDI = 6'h08;
	localparam mips_ex_pkg::opcode_t OP_SLTI = 6'h0a;
	localparam mips_ex_pkg::opcode_t OP_ANDI = 6'h0c;
	localparam mips_ex_pkg::opcode_t OP_ORI = 6'h0d;
	localparam mips_ex_pkg::funct_t FN_SLL = 6'h00;
	localparam mips_ex_pkg::funct_t FN_SRL = 6'h02;
	localparam mips_ex_pkg::funct_t FN_MFHI = 6'h10;
	localparam mips_ex_pkg::funct_t FN_MFLO = 6'h12;
	localparam mips_ex_pkg::funct_t FN_MULT = 6'h18;
	localparam mips_ex_pkg::funct_t FN_DIV = 6'h1a;
	localparam mips_ex_pkg::funct_t FN_ADD = 6'h20;
	localparam mips_ex_pkg::funct_t FN_SUB = 6'h22;
	localparam mips_ex_pkg::funct_t FN_AND = 6'h24;
	localparam mips_ex_pkg::funct_t FN_OR = 6'h25;
	localparam mips_ex_pkg::funct_t FN_NOR = 6'h27;
	localparam mips_ex_pkg::funct_t FN_SLT = 6'h2a;
	localparam mips_ex_pkg::funct_t FN_MUL = 6'h02; // Under SPECIAL2

	logic clk;
	logic reset;
	logic in_valid;
	mips_ex_pkg::opcode_t opcode;
	mips_ex_pkg::funct_t funct;
	mips_ex_pkg::shamt_t shamt;
	mips_ex_pkg::imm_t imm;
	mips_ex_pkg::word_t rs_value;
	mips_ex_pkg::word_t rt_value;
	logic in_ready;
	logic out_valid;
	mips_ex_pkg::word_t result;
	logic branch;
	logic branch_taken;
	logic illegal;
	int seed = 58962;
	int cycles = 0; // Rising edges so far
	int checks = 0;
	int errors = 0;
	mips_ex_pkg::word_t exp_result_q[$]; // In issue order
	logic [2:0] exp_flags_q[$];
	int due_q[$]; // Cycle at which each result must show

	`include "tb_ex_tasks.svh"

	ex_stage ex_stage_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	initial
	begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("Run stopped by timeout after %0d cycles", cycles);
		$display("Errors found");
		$finish;
	end

	// Result checker, outputs are stable on the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (due_q.size() > 0 && due_q[0] == cycles)
			begin
				if (!out_valid)
				begin
					errors++;
					$display("out_valid missing at %0t for an accepted instruction", $time);
				end
				check_word("result", result, exp_result_q[0]);
				check_flag("branch", branch, exp_flags_q[0][2]);
				check_flag("branch_taken", branch_taken, exp_flags_q[0][1]);
				check_flag("illegal", illegal, exp_flags_q[0][0]);
				void'(exp_result_q.pop_front());
				void'(exp_flags_q.pop_front());
				void'(due_q.pop_front());
			end
			else if (out_valid)
			begin
				errors++;
				$display("out_valid high at %0t with no result due", $time);
			end
		end
	end

	task automatic test_rtype();
		mips_ex_pkg::word_t a;
		mips_ex_pkg::word_t b;
		for (int i = 0; i < 8; i++)
		begin
			a = $random(seed);
			b = $random(seed);
			a[`EX_DATA_W-1] = i[0]; // All four sign pairs
			b[`EX_DATA_W-1] = i[1];
			issue(OP_RTYPE, FN_ADD, '0, '0, a, b, 1'b1, a + b, 3'b000);
			issue(OP_RTYPE, FN_SUB, '0, '0, a, b, 1'b1, a - b, 3'b000);
			issue(OP_RTYPE, FN_AND, '0, '0, a, b, 1'b1, a & b, 3'b000);
			issue(OP_RTYPE, FN_OR, '0, '0, a, b, 1'b1, a | b, 3'b000);
			issue(OP_RTYPE, FN_NOR, '0, '0, a, b, 1'b1, ~(a | b), 3'b000);
			issue(OP_RTYPE, FN_SLT, '0, '0, a, b, 1'b1, ref_slt(a, b), 3'b000);
			issue(OP_SPECIAL2, FN_MUL, '0, '0, a, b, 1'b1, a * b, 3'b000); // Low word
		end
	endtask

	task automatic test_shifts();
		mips_ex_pkg::word_t a;
		mips_ex_pkg::word_t b;
		mips_ex_pkg::shamt_t sh;
		for (int i = 0; i < 6; i++)
		begin
			a = $random(seed); // rs is not shifted
			b = $random(seed);
			sh = mips_ex_pkg::shamt_t'($random(seed));
			if (i == 0)
				sh = '0;
			if (i == 1)
				sh = mips_ex_pkg::shamt_t'(1);
			if (i == 2)
				sh = '1;
			issue(OP_RTYPE, FN_SLL, sh, '0, a, b, 1'b1, b << sh, 3'b000);
			issue(OP_RTYPE, FN_SRL, sh, '0, a, b, 1'b1, b >> sh, 3'b000);
		end
	endtask

	task automatic test_itype();
		mips_ex_pkg::word_t a;
		mips_ex_pkg::word_t b;
		mips_ex_pkg::imm_t im;
		for (int i = 0; i < 4; i++)
		begin
			a = $random(seed);
			b = $random(seed); // Must be ignored
			im = mips_ex_pkg::imm_t'($random(seed));
			im[$bits(im)-1] = i[0]; // Sign bit set on odd passes
			issue(OP_ADDI, '0, '0, im, a, b, 1'b1, a + ref_sext(im), 3'b000);
			issue(OP_SLTI, '0, '0, im, a, b, 1'b1, ref_slt(a, ref_sext(im)), 3'b000);
			issue(OP_ANDI, '0, '0, im, a, b, 1'b1, a & ref_zext(im), 3'b000);
			issue(OP_ORI, '0, '0, im, a, b, 1'b1, a | ref_zext(im), 3'b000);
		end
	endtask

	task automatic test_branches();
		mips_ex_pkg::word_t a;
		mips_ex_pkg::word_t b;
		mips_ex_pkg::imm_t im;
		for (int i = 0; i < 2; i++)
		begin
			im = mips_ex_pkg::imm_t'($random(seed));
			b = ref_sext(im); // rt equal to the extended offset
			a = (i == 0) ? b : ~b;
			issue(OP_BEQ, '0, '0, im, a, b, 1'b1, a - b, {1'b1, i == 0, 1'b0});
			issue(OP_BNE, '0, '0, im, a, b, 1'b1, a - b, {1'b1, i == 1, 1'b0});
		end
	endtask

	task automatic test_muldiv();
		mips_ex_pkg::word_t a;
		mips_ex_pkg::word_t b;
		mips_ex_pkg::word_t q;
		mips_ex_pkg::word_t r;
		logic [2*`EX_DATA_W-1:0] p;
		for (int k = 0; k < 4; k++)
		begin
			a = $random(seed);
			a[`EX_DATA_W-1] = 1'b0;
			b = ($random(seed) & 'hffff) | 1; // Small nonzero divisor
			if (k[0])
				a = -a;
			if (k[1])
				b = -b;
			p = ref_mult(a, b);
			run_muldiv(FN_MULT, a, b, p[2*`EX_DATA_W-1:`EX_DATA_W], p[`EX_DATA_W-1:0]);
			ref_div(a, b, q, r);
			run_muldiv(FN_DIV, a, b, r, q); // Hi remainder, Lo quotient
		end
		a = $random(seed);
		a[`EX_DATA_W-1] = 1'b1;
		ref_div(a, '0, q, r);
		run_muldiv(FN_DIV, a, '0, r, q);
	endtask

	task automatic test_illegal();
		issue(6'h3f, '0, '0, '0, '1, '1, 1'b1, '0, 3'b001); // Unknown opcode
		issue(OP_RTYPE, 6'h3f, '0, '0, '1, '1, 1'b1, '0, 3'b001); // Unknown funct
	endtask

	initial
	begin
		reset = 1'b1;
		in_valid = 1'b0;
		opcode = '0;
		funct = '0;
		shamt = '0;
		imm = '0;
		rs_value = '0;
		rt_value = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);
		test_rtype();
		test_shifts();
		test_itype();
		test_branches();
		drain();
		test_muldiv();
		test_illegal();
		drain();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- compile.f
+incdir+.
mips_ex_pkg.sv
alu_decoder.sv
alu.sv
muldiv_unit.sv
ex_stage.sv
tb_ex_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ex_stage
FILELIST = compile.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
